// File: common/sya_consts.svh
/*
 * Array geometry and datapath widths of the systolic convolution engine.
 * Included by the package and by every RTL module that sizes a port.
 */
`ifndef SYA_CONSTS_SVH
`define SYA_CONSTS_SVH

// ==============================
// Array geometry
// ==============================
`define SYA_NUM_ROW     4
`define SYA_NUM_COL     4

// ==============================
// Datapath widths
// ==============================
`define SYA_DAT_WIDTH   8
`define SYA_ACC_WIDTH   26
`define SYA_CHN_WIDTH   10
`define SYA_IDX_WIDTH   16
`define SYA_ADDR_WIDTH  16

// Zero steps after the last channel so the skew empties
`define SYA_FLUSH_LEN   (`SYA_NUM_ROW + `SYA_NUM_COL - 1)

`endif

// File: common/sya_pkg.sv
/*
 * Shared types of the systolic engine: controller states, the configuration,
 * loop indices and the payloads of the read and output write channels.
 */
`include "sya_consts.svh"

package sya_pkg;

    typedef enum logic [1:0] {
        IDLE,
        FEED,
        FLUSH,
        DRAIN
    } sya_state_e;

    typedef struct packed {
        logic [`SYA_CHN_WIDTH-1:0]  chn;
        logic [`SYA_IDX_WIDTH-1:0]  grp_per_tile;
        logic [`SYA_IDX_WIDTH-1:0]  num_til_ifm;
        logic [`SYA_IDX_WIDTH-1:0]  num_til_flt;
        // 0 puts the filter tile loop inside, 1 the input tile loop
        logic                       loop_ord;
        logic [`SYA_ADDR_WIDTH-1:0] act_base;
        logic [`SYA_ADDR_WIDTH-1:0] wgt_base;
        logic [`SYA_ADDR_WIDTH-1:0] ofm_base;
        logic [4:0]                 shift;
        logic [`SYA_DAT_WIDTH-1:0]  zp;
    } sya_cfg_t;

    typedef struct packed {
        logic [`SYA_CHN_WIDTH-1:0]  chn;
        logic [`SYA_IDX_WIDTH-1:0]  grp;
        logic [`SYA_IDX_WIDTH-1:0]  til_ifm;
        logic [`SYA_IDX_WIDTH-1:0]  til_flt;
        logic [`SYA_IDX_WIDTH-1:0]  blk;
    } sya_idx_t;

    typedef struct packed {
        logic [`SYA_ADDR_WIDTH-1:0] act_addr;
        logic [`SYA_ADDR_WIDTH-1:0] wgt_addr;
    } sya_rd_req_t;

    typedef struct packed {
        logic [`SYA_NUM_ROW-1:0][`SYA_DAT_WIDTH-1:0] act;
        logic [`SYA_NUM_COL-1:0][`SYA_DAT_WIDTH-1:0] wgt;
    } sya_rd_dat_t;

    typedef struct packed {
        logic [`SYA_ADDR_WIDTH-1:0]                  addr;
        logic [`SYA_NUM_COL-1:0][`SYA_DAT_WIDTH-1:0] dat;
    } sya_ofm_wr_t;

    typedef logic [`SYA_NUM_COL-1:0][`SYA_ACC_WIDTH-1:0] sya_acc_row_t;

endpackage

// File: filelist.f
+incdir+common
common/sya_pkg.sv
pe_array/sya_pe.sv
pe_array/sya_pe_array.sv
rtl/sya_addr_gen.sv
rtl/sya_ctrl.sv
rtl/sya_ofm_quant.sv
rtl/sya_top.sv
tb/sya_checker.sv
tb/sya_tb.sv

// File: pe_array/sya_pe.sv
/*
 * Processing element of the systolic grid. Forwards the activation east and
 * the weight south and accumulates their signed product in place.
 */
`include "sya_consts.svh"
`timescale 1ns/1ps

module sya_pe (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             en,
    input  logic                             clr,
    input  logic signed [`SYA_DAT_WIDTH-1:0] act_w,
    input  logic signed [`SYA_DAT_WIDTH-1:0] wgt_n,
    output logic signed [`SYA_DAT_WIDTH-1:0] act_e,
    output logic signed [`SYA_DAT_WIDTH-1:0] wgt_s,
    output logic signed [`SYA_ACC_WIDTH-1:0] acc
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_e <= '0;
            wgt_s <= '0;
        end else if (en) begin
            act_e <= act_w;
            wgt_s <= wgt_n;
        end
    end

    // Output stationary sum, kept until the row is drained
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            acc <= '0;
        else if (clr)
            acc <= '0;
        else if (en)
            acc <= acc + act_w * wgt_n;
    end

endmodule

// File: pe_array/sya_pe_array.sv
/*
 * Grid of processing elements with its input skew. Activations enter from
 * the west and weights from the north, each lane delayed by its position.
 * The accumulators of one row are selected out for draining.
 */
`include "sya_consts.svh"
`timescale 1ns/1ps

module sya_pe_array
    import sya_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            en,
    input  logic                            clr,
    input  logic                            dat_sel,
    input  sya_rd_dat_t                     rd_dat,
    input  logic [$clog2(`SYA_NUM_ROW)-1:0] row_sel,
    output sya_acc_row_t                    acc_row
);

    // Activation lanes first, then weight lanes
    localparam int NUM_LANE = `SYA_NUM_ROW + `SYA_NUM_COL;

    logic [NUM_LANE-1:0][`SYA_DAT_WIDTH-1:0]                       lane_in;
    wire  [NUM_LANE-1:0][`SYA_DAT_WIDTH-1:0]                       lane_out;
    wire  [`SYA_NUM_ROW-1:0][`SYA_NUM_COL:0][`SYA_DAT_WIDTH-1:0]   act_h;
    wire  [`SYA_NUM_ROW:0][`SYA_NUM_COL-1:0][`SYA_DAT_WIDTH-1:0]   wgt_v;
    wire  [`SYA_NUM_ROW-1:0][`SYA_NUM_COL-1:0][`SYA_ACC_WIDTH-1:0] acc_all;

    // Flush steps feed zeros
    assign lane_in = dat_sel ? '0 : {rd_dat.wgt, rd_dat.act};

    // ==============================
    // Triangular skew
    // ==============================
    for (genvar l = 0; l < NUM_LANE; l++) begin : g_skew
        localparam int DLY = (l < `SYA_NUM_ROW) ? l : l - `SYA_NUM_ROW;
        if (DLY == 0) begin : g_direct
            assign lane_out[l] = lane_in[l];
        end else begin : g_delay
            logic [DLY-1:0][`SYA_DAT_WIDTH-1:0] sr;
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    sr <= '0;
                end else if (en) begin
                    sr[0] <= lane_in[l];
                    for (int k = 1; k < DLY; k++)
                        sr[k] <= sr[k-1];
                end
            end
            assign lane_out[l] = sr[DLY-1];
        end
    end

    // ==============================
    // Grid
    // ==============================
    for (genvar r = 0; r < `SYA_NUM_ROW; r++) begin : g_west
        assign act_h[r][0] = lane_out[r];
    end

    for (genvar c = 0; c < `SYA_NUM_COL; c++) begin : g_north
        assign wgt_v[0][c] = lane_out[`SYA_NUM_ROW + c];
    end

    for (genvar r = 0; r < `SYA_NUM_ROW; r++) begin : g_row
        for (genvar c = 0; c < `SYA_NUM_COL; c++) begin : g_col
            sya_pe u_pe (
                .clk   (clk),
                .rst_n (rst_n),
                .en    (en),
                .clr   (clr),
                .act_w (act_h[r][c]),
                .wgt_n (wgt_v[r][c]),
                .act_e (act_h[r][c+1]),
                .wgt_s (wgt_v[r+1][c]),
                .acc   (acc_all[r][c])
            );
        end
    end

    assign acc_row = acc_all[row_sel];

endmodule

// File: rtl/sya_addr_gen.sv
/*
 * Address arithmetic for the buffer. Turns the loop position into the
 * activation and weight read addresses and the output block base.
 */
`include "sya_consts.svh"
`timescale 1ns/1ps

module sya_addr_gen
    import sya_pkg::*;
(
    input  sya_cfg_t                   cfg_q,
    input  sya_idx_t                   idx,
    output sya_rd_req_t                rd_req,
    output logic [`SYA_ADDR_WIDTH-1:0] ofm_blk_addr
);

    logic [`SYA_ADDR_WIDTH-1:0] tile_len;
    logic [`SYA_ADDR_WIDTH-1:0] ifm_off;
    logic [`SYA_ADDR_WIDTH-1:0] flt_off;
    logic [`SYA_ADDR_WIDTH-1:0] grp_off;

    // Words in one tile: every channel of every group
    assign tile_len = cfg_q.chn * cfg_q.grp_per_tile;
    assign ifm_off  = tile_len * idx.til_ifm;
    assign flt_off  = tile_len * idx.til_flt;
    // Group start plus current channel, common to both operands
    assign grp_off  = cfg_q.chn * idx.grp + idx.chn;

    assign rd_req = '{
        act_addr: cfg_q.act_base + ifm_off + grp_off,
        wgt_addr: cfg_q.wgt_base + flt_off + grp_off
    };

    // One output word per array row in each block
    assign ofm_blk_addr = cfg_q.ofm_base + idx.blk * `SYA_NUM_ROW;

endmodule

// File: rtl/sya_ctrl.sv
/*
 * Sequencer of the engine. Walks channel, group and tile loops, issues read
 * requests, steps the array on data beats, then flushes and drains it.
 */
`include "sya_consts.svh"
`timescale 1ns/1ps

module sya_ctrl
    import sya_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  sya_cfg_t                        cfg,
    input  logic                            cfg_vld,
    output logic                            cfg_rdy,
    output sya_cfg_t                        cfg_q,
    output sya_idx_t                        idx,
    output logic                            rd_req_vld,
    input  logic                            rd_req_rdy,
    input  logic                            rd_dat_vld,
    output logic                            rd_dat_rdy,
    input  logic                            ofm_wr_rdy,
    output logic                            arr_en,
    output logic                            arr_clr,
    output logic                            arr_dat_sel,
    output logic [$clog2(`SYA_NUM_ROW)-1:0] drain_row,
    output logic                            drain_vld,
    input  logic                            drain_done
);

    localparam int FLUSH_CNT_W = $clog2(`SYA_FLUSH_LEN);

    sya_state_e                state;
    sya_state_e                state_nxt;
    sya_idx_t                  idx_nxt;
    logic                      req_done;
    logic [`SYA_CHN_WIDTH-1:0] beat_cnt;
    logic [FLUSH_CNT_W-1:0]    flush_cnt;
    logic                      req_hs;
    logic                      beat;
    logic                      last_req;
    logic                      last_beat;
    logic                      flush_end;
    logic                      grp_last;
    logic                      ifm_last;
    logic                      flt_last;

    assign req_hs    = rd_req_vld & rd_req_rdy;
    assign beat      = rd_dat_vld & rd_dat_rdy;
    assign last_req  = idx.chn == cfg_q.chn - 1'b1;
    assign last_beat = beat_cnt == cfg_q.chn - 1'b1;
    assign flush_end = flush_cnt == `SYA_FLUSH_LEN - 1;
    assign grp_last  = idx.grp == cfg_q.grp_per_tile - 1'b1;
    assign ifm_last  = idx.til_ifm == cfg_q.num_til_ifm - 1'b1;
    assign flt_last  = idx.til_flt == cfg_q.num_til_flt - 1'b1;

    assign cfg_rdy     = state == IDLE;
    assign rd_req_vld  = (state == FEED) && !req_done;
    assign rd_dat_rdy  = state == FEED;
    // Array steps on every beat and on every flush cycle
    assign arr_en      = beat || (state == FLUSH);
    assign arr_dat_sel = state == FLUSH;
    assign arr_clr     = drain_done;
    assign drain_vld   = state == DRAIN;

    // ==============================
    // State machine
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:  if (cfg_vld) state_nxt = FEED;
            FEED:  if (beat && last_beat) state_nxt = FLUSH;
            FLUSH: if (flush_end) state_nxt = DRAIN;
            DRAIN: begin
                if (drain_done)
                    state_nxt = (grp_last && ifm_last && flt_last) ? IDLE : FEED;
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Next group position with the inner tile loop picked by loop_ord
    always_comb begin
        idx_nxt     = idx;
        idx_nxt.grp = grp_last ? '0 : idx.grp + 1'b1;
        idx_nxt.blk = idx.blk + 1'b1;
        if (grp_last) begin
            if (cfg_q.loop_ord) begin
                idx_nxt.til_ifm = ifm_last ? '0 : idx.til_ifm + 1'b1;
                if (ifm_last)
                    idx_nxt.til_flt = idx.til_flt + 1'b1;
            end else begin
                idx_nxt.til_flt = flt_last ? '0 : idx.til_flt + 1'b1;
                if (flt_last)
                    idx_nxt.til_ifm = idx.til_ifm + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_vld && cfg_rdy)
            cfg_q <= cfg;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            idx       <= '0;
            req_done  <= 1'b0;
            beat_cnt  <= '0;
            flush_cnt <= '0;
            drain_row <= '0;
        end else begin
            state <= state_nxt;
            if (cfg_vld && cfg_rdy) begin
                idx      <= '0;
                req_done <= 1'b0;
            end else if (drain_done) begin
                idx      <= idx_nxt;
                req_done <= 1'b0;
            end else if (req_hs) begin
                idx.chn  <= last_req ? '0 : idx.chn + 1'b1;
                req_done <= last_req;
            end
            if (beat)
                beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
            if (state == FLUSH)
                flush_cnt <= flush_end ? '0 : flush_cnt + 1'b1;
            if (drain_vld && ofm_wr_rdy)
                drain_row <= drain_done ? '0 : drain_row + 1'b1;
        end
    end

    // ==============================
    // Checks
    // ==============================
    // A data beat never runs ahead of its read request
    a_beat_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        beat |-> req_done || idx.chn > beat_cnt);

    // A stalled request keeps its loop position and so its addresses
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_vld && !rd_req_rdy |=> rd_req_vld && $stable(idx));

    // Each drain begins at row 0
    a_drain_start: assert property (@(posedge clk) disable iff (!rst_n)
        state == FLUSH && flush_end |=> drain_vld && drain_row == '0);

endmodule

// File: rtl/sya_ofm_quant.sv
/*
 * Output stage. Quantizes the selected accumulator row to bytes and offers
 * it as one output write at the block address plus the row number.
 */
`include "sya_consts.svh"
`timescale 1ns/1ps

module sya_ofm_quant
    import sya_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  sya_acc_row_t                    acc_row,
    input  logic [4:0]                      shift,
    input  logic [`SYA_DAT_WIDTH-1:0]       zp,
    input  logic [$clog2(`SYA_NUM_ROW)-1:0] drain_row,
    input  logic                            drain_vld,
    input  logic [`SYA_ADDR_WIDTH-1:0]      ofm_blk_addr,
    input  logic                            ofm_wr_rdy,
    output sya_ofm_wr_t                     ofm_wr,
    output logic                            ofm_wr_vld,
    output logic                            drain_done
);

    wire [`SYA_NUM_COL-1:0][`SYA_DAT_WIDTH-1:0] q_dat;

    for (genvar c = 0; c < `SYA_NUM_COL; c++) begin : g_quant
        logic [`SYA_ACC_WIDTH-1:0] sh;
        assign sh = acc_row[c] >> shift;
        // Negative sums clamp to zero, zp wraps modulo 256
        assign q_dat[c] = acc_row[c][`SYA_ACC_WIDTH-1] ? '0 : sh[`SYA_DAT_WIDTH-1:0] + zp;
    end

    assign ofm_wr = '{
        addr: ofm_blk_addr + drain_row,
        dat:  q_dat
    };
    assign ofm_wr_vld = drain_vld;
    // Last row accepted ends the group
    assign drain_done = drain_vld && ofm_wr_rdy && (drain_row == `SYA_NUM_ROW - 1);

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr_vld && !ofm_wr_rdy |=> ofm_wr_vld && $stable(ofm_wr));

endmodule

// File: rtl/sya_top.sv
/*
 * Top level of the output-stationary systolic engine.
 * Takes one configuration, streams activation and weight vectors from the
 * buffer and writes quantized output rows back, one row per accepted write.
 */
`include "sya_consts.svh"
`timescale 1ns/1ps

module sya_top
    import sya_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  sya_cfg_t    cfg,
    input  logic        cfg_vld,
    output logic        cfg_rdy,
    output sya_rd_req_t rd_req,
    output logic        rd_req_vld,
    input  logic        rd_req_rdy,
    input  sya_rd_dat_t rd_dat,
    input  logic        rd_dat_vld,
    output logic        rd_dat_rdy,
    output sya_ofm_wr_t ofm_wr,
    output logic        ofm_wr_vld,
    input  logic        ofm_wr_rdy
);

    sya_cfg_t                        cfg_q;
    sya_idx_t                        idx;
    sya_acc_row_t                    acc_row;
    logic [`SYA_ADDR_WIDTH-1:0]      ofm_blk_addr;
    logic [$clog2(`SYA_NUM_ROW)-1:0] drain_row;
    logic                            drain_vld;
    logic                            drain_done;
    logic                            arr_en;
    logic                            arr_clr;
    logic                            arr_dat_sel;

    sya_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .cfg_vld     (cfg_vld),
        .cfg_rdy     (cfg_rdy),
        .cfg_q       (cfg_q),
        .idx         (idx),
        .rd_req_vld  (rd_req_vld),
        .rd_req_rdy  (rd_req_rdy),
        .rd_dat_vld  (rd_dat_vld),
        .rd_dat_rdy  (rd_dat_rdy),
        .ofm_wr_rdy  (ofm_wr_rdy),
        .arr_en      (arr_en),
        .arr_clr     (arr_clr),
        .arr_dat_sel (arr_dat_sel),
        .drain_row   (drain_row),
        .drain_vld   (drain_vld),
        .drain_done  (drain_done)
    );

    sya_addr_gen u_addr_gen (
        .cfg_q        (cfg_q),
        .idx          (idx),
        .rd_req       (rd_req),
        .ofm_blk_addr (ofm_blk_addr)
    );

    sya_pe_array u_pe_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (arr_en),
        .clr     (arr_clr),
        .dat_sel (arr_dat_sel),
        .rd_dat  (rd_dat),
        .row_sel (drain_row),
        .acc_row (acc_row)
    );

    sya_ofm_quant u_ofm_quant (
        .clk          (clk),
        .rst_n        (rst_n),
        .acc_row      (acc_row),
        .shift        (cfg_q.shift),
        .zp           (cfg_q.zp),
        .drain_row    (drain_row),
        .drain_vld    (drain_vld),
        .ofm_blk_addr (ofm_blk_addr),
        .ofm_wr_rdy   (ofm_wr_rdy),
        .ofm_wr       (ofm_wr),
        .ofm_wr_vld   (ofm_wr_vld),
        .drain_done   (drain_done)
    );

endmodule

// File: tb/sya_checker.sv
/*
 * Checker of the systolic engine. Rebuilds the expected read requests and
 * output writes of each configuration from the buffer contents and compares
 * the accepted transfers in order.
 */
`include "sya_consts.svh"
`timescale 1ns/1ps

module sya_checker
    import sya_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  sya_cfg_t                               cfg,
    input  logic                                   cfg_vld,
    input  logic                                   cfg_rdy,
    input  sya_rd_req_t                            rd_req,
    input  logic                                   rd_req_vld,
    input  logic                                   rd_req_rdy,
    input  logic                                   rd_dat_rdy,
    input  sya_ofm_wr_t                            ofm_wr,
    input  logic                                   ofm_wr_vld,
    input  logic                                   ofm_wr_rdy,
    input  logic [`SYA_NUM_ROW*`SYA_DAT_WIDTH-1:0] act_mem [0:(1<<`SYA_ADDR_WIDTH)-1],
    input  logic [`SYA_NUM_COL*`SYA_DAT_WIDTH-1:0] wgt_mem [0:(1<<`SYA_ADDR_WIDTH)-1],
    output int                                     err_cnt = 0,
    output int                                     chk_cnt = 0,
    output int                                     wr_cnt = 0,
    output int                                     pend_wr = 0
);

    logic [31:0] exp_req [$];
    logic [47:0] exp_wr [$];
    logic        seen_idle;
    logic        cfg_taken;
    logic        rdy_q;

    function automatic logic [7:0] quantize(int acc, int sh, logic [7:0] zp);
        logic [31:0] v;
        if (acc < 0)
            return 8'd0;
        v = acc >> sh;
        return v[7:0] + zp;
    endfunction

    task automatic check_eq(input string what, input logic [47:0] got, input logic [47:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Reference walk: tiles outer, group, then channels
    task automatic build_expected(input sya_cfg_t c);
        int          n_out;
        int          n_in;
        int          blk;
        int          til_ifm;
        int          til_flt;
        int          acc [`SYA_NUM_ROW][`SYA_NUM_COL];
        logic [15:0] tile_len;
        logic [15:0] a_addr;
        logic [15:0] w_addr;
        logic [15:0] o_addr;
        logic [31:0] dat;
        n_out    = c.loop_ord ? c.num_til_flt : c.num_til_ifm;
        n_in     = c.loop_ord ? c.num_til_ifm : c.num_til_flt;
        tile_len = c.chn * c.grp_per_tile;
        blk      = 0;
        for (int o = 0; o < n_out; o++) begin
            for (int i = 0; i < n_in; i++) begin
                for (int g = 0; g < c.grp_per_tile; g++) begin
                    til_ifm = c.loop_ord ? i : o;
                    til_flt = c.loop_ord ? o : i;
                    foreach (acc[r, col])
                        acc[r][col] = 0;
                    for (int k = 0; k < c.chn; k++) begin
                        a_addr = c.act_base + tile_len * til_ifm + c.chn * g + k;
                        w_addr = c.wgt_base + tile_len * til_flt + c.chn * g + k;
                        exp_req.push_back({a_addr, w_addr});
                        foreach (acc[r, col])
                            acc[r][col] += $signed(act_mem[a_addr][8*r +: 8]) *
                                           $signed(wgt_mem[w_addr][8*col +: 8]);
                    end
                    for (int r = 0; r < `SYA_NUM_ROW; r++) begin
                        for (int col = 0; col < `SYA_NUM_COL; col++)
                            dat[8*col +: 8] = quantize(acc[r][col], c.shift, c.zp);
                        o_addr = c.ofm_base + 4 * blk + r;
                        exp_wr.push_back({o_addr, dat});
                    end
                    blk++;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            seen_idle = 1'b0;
            cfg_taken = 1'b0;
            rdy_q     = 1'b1;
        end else begin
            if (!seen_idle) begin
                check_eq("idle outputs after reset", {cfg_rdy, rd_req_vld, rd_dat_rdy,
                         ofm_wr_vld}, 4'b1000);
                seen_idle = 1'b1;
            end
            if (cfg_taken) begin
                check_eq("cfg_rdy after configuration", cfg_rdy, 1'b0);
                cfg_taken = 1'b0;
            end
            if (cfg_rdy && !rdy_q && (exp_wr.size() != 0 || exp_req.size() != 0)) begin
                err_cnt++;
                $display("FAIL %0t: engine went idle with %0d reads and %0d writes missing",
                         $time, exp_req.size(), exp_wr.size());
                exp_req.delete();
                exp_wr.delete();
            end
            if (cfg_vld && cfg_rdy) begin
                build_expected(cfg);
                cfg_taken = 1'b1;
            end
            if (rd_req_vld && rd_req_rdy) begin
                if (exp_req.size() == 0) begin
                    err_cnt++;
                    $display("FAIL %0t: unexpected read request %h", $time, rd_req);
                end else begin
                    check_eq("read request addresses", rd_req, exp_req.pop_front());
                end
            end
            if (ofm_wr_vld && ofm_wr_rdy) begin
                wr_cnt++;
                if (exp_wr.size() == 0) begin
                    err_cnt++;
                    $display("FAIL %0t: unexpected output write %h", $time, ofm_wr);
                end else begin
                    check_eq("output write", ofm_wr, exp_wr.pop_front());
                end
            end
            rdy_q   = cfg_rdy;
            pend_wr = exp_wr.size();
        end
    end

endmodule

// File: tb/sya_tb.sv
/*
 * Testbench top of the systolic engine. Drives random configurations,
 * models the activation and weight buffer with random stalls and latency,
 * and hands the port traffic to the checker.
 */
`include "sya_consts.svh"
`timescale 1ns/1ps

module sya_tb
    import sya_pkg::*;
;

    localparam int TIMEOUT   = 5000;
    localparam int NUM_TESTS = 3;
    localparam int MEM_DEPTH = 1 << `SYA_ADDR_WIDTH;

    logic        clk;
    logic        rst_n;
    sya_cfg_t    cfg;
    logic        cfg_vld;
    logic        cfg_rdy;
    sya_rd_req_t rd_req;
    logic        rd_req_vld;
    logic        rd_req_rdy;
    sya_rd_dat_t rd_dat;
    logic        rd_dat_vld;
    logic        rd_dat_rdy;
    sya_ofm_wr_t ofm_wr;
    logic        ofm_wr_vld;
    logic        ofm_wr_rdy;

    logic [`SYA_NUM_ROW*`SYA_DAT_WIDTH-1:0] act_mem [0:MEM_DEPTH-1];
    logic [`SYA_NUM_COL*`SYA_DAT_WIDTH-1:0] wgt_mem [0:MEM_DEPTH-1];

    // Outstanding reads of the buffer model
    logic [`SYA_ADDR_WIDTH-1:0] pend_act [$];
    logic [`SYA_ADDR_WIDTH-1:0] pend_wgt [$];
    int                         pend_due [$];

    int seed = 22;
    int cyc  = 0;
    int dly;
    int last_due;
    int err_cnt;
    int chk_cnt;
    int wr_cnt;
    int pend_wr;
    bit timed_out = 0;

    sya_top sya_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .cfg_vld    (cfg_vld),
        .cfg_rdy    (cfg_rdy),
        .rd_req     (rd_req),
        .rd_req_vld (rd_req_vld),
        .rd_req_rdy (rd_req_rdy),
        .rd_dat     (rd_dat),
        .rd_dat_vld (rd_dat_vld),
        .rd_dat_rdy (rd_dat_rdy),
        .ofm_wr     (ofm_wr),
        .ofm_wr_vld (ofm_wr_vld),
        .ofm_wr_rdy (ofm_wr_rdy)
    );

    sya_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .cfg_vld    (cfg_vld),
        .cfg_rdy    (cfg_rdy),
        .rd_req     (rd_req),
        .rd_req_vld (rd_req_vld),
        .rd_req_rdy (rd_req_rdy),
        .rd_dat_rdy (rd_dat_rdy),
        .ofm_wr     (ofm_wr),
        .ofm_wr_vld (ofm_wr_vld),
        .ofm_wr_rdy (ofm_wr_rdy),
        .act_mem    (act_mem),
        .wgt_mem    (wgt_mem),
        .err_cnt    (err_cnt),
        .chk_cnt    (chk_cnt),
        .wr_cnt     (wr_cnt),
        .pend_wr    (pend_wr)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ==============================
    // Buffer model
    // ==============================
    always @(posedge clk) begin
        cyc++;
        if (!rst_n) begin
            pend_act.delete();
            pend_wgt.delete();
            pend_due.delete();
            last_due = 0;
        end else begin
            if (rd_dat_vld && rd_dat_rdy) begin
                void'(pend_act.pop_front());
                void'(pend_wgt.pop_front());
                void'(pend_due.pop_front());
            end
            if (rd_req_vld && rd_req_rdy) begin
                // In order return 0 to 3 cycles late
                dly      = $unsigned($random(seed)) % 4;
                last_due = (cyc + dly > last_due) ? cyc + dly : last_due;
                pend_act.push_back(rd_req.act_addr);
                pend_wgt.push_back(rd_req.wgt_addr);
                pend_due.push_back(last_due);
            end
        end
        #1;
        rd_req_rdy = (($random(seed) & 3) != 0) && rst_n;
        ofm_wr_rdy = (($random(seed) & 3) != 0) && rst_n;
        if (pend_due.size() != 0 && pend_due[0] <= cyc) begin
            rd_dat_vld = 1'b1;
            rd_dat     = '{act: act_mem[pend_act[0]], wgt: wgt_mem[pend_wgt[0]]};
        end else begin
            rd_dat_vld = 1'b0;
            rd_dat     = '0;
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic make_cfg(input int t, output sya_cfg_t c);
        c              = '0;
        c.chn          = (t == 2) ? 1 : 2 + ($unsigned($random(seed)) % 5);
        c.grp_per_tile = 1 + ($unsigned($random(seed)) % 3);
        // Two tiles each way so the loop order shows
        c.num_til_ifm  = (t < 2) ? 2 : 1 + ($unsigned($random(seed)) % 2);
        c.num_til_flt  = (t < 2) ? 2 : 1 + ($unsigned($random(seed)) % 2);
        c.loop_ord     = (t == 2) ? $random(seed) : (t == 1);
        c.act_base     = $random(seed);
        c.wgt_base     = $random(seed);
        c.ofm_base     = $random(seed);
        c.shift        = $unsigned($random(seed)) % 12;
        c.zp           = $random(seed);
    endtask

    task automatic send_cfg(input sya_cfg_t c, output bit ok);
        ok      = 0;
        cfg     = c;
        cfg_vld = 1'b1;
        for (int n = 0; n < TIMEOUT; n++) begin
            if (cfg_rdy) begin
                @(posedge clk);
                ok = 1;
                break;
            end
            @(posedge clk);
            #1;
        end
        #1;
        cfg_vld = 1'b0;
        if (!ok)
            $display("Timeout: configuration was never accepted");
    endtask

    task automatic wait_idle(output bit ok);
        ok = 0;
        for (int n = 0; n < TIMEOUT; n++) begin
            @(posedge clk);
            #1;
            if (pend_wr == 0 && cfg_rdy) begin
                ok = 1;
                break;
            end
        end
        if (!ok)
            $display("Timeout: %0d output writes still missing or engine not idle", pend_wr);
    endtask

    initial begin
        sya_cfg_t c;
        bit       ok;
        int       t;
        int       a;
        int       err_before;
        cfg        = '0;
        cfg_vld    = 1'b0;
        rd_req_rdy = 1'b0;
        rd_dat     = '0;
        rd_dat_vld = 1'b0;
        ofm_wr_rdy = 1'b0;
        rst_n      = 1'b0;
        for (a = 0; a < MEM_DEPTH; a++) begin
            act_mem[a] = $random(seed);
            wgt_mem[a] = $random(seed);
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        for (t = 0; t < NUM_TESTS && !timed_out; t++) begin
            err_before = err_cnt;
            make_cfg(t, c);
            send_cfg(c, ok);
            if (ok)
                wait_idle(ok);
            timed_out = !ok;
            $display("test %0d: loop_ord=%0d chn=%0d blocks=%0d, %0d errors%s", t,
                     c.loop_ord, c.chn, c.grp_per_tile * c.num_til_ifm * c.num_til_flt,
                     err_cnt - err_before, timed_out ? ", timed out" : "");
        end
        $display("tests=%0d checks=%0d writes=%0d errors=%0d timeouts=%0d",
                 t, chk_cnt, wr_cnt, err_cnt, timed_out);
        if (err_cnt == 0 && !timed_out)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
